//--- include/ddr2_cpu_regs.svh
`ifndef DDR2_CPU_REGS_SVH
`define DDR2_CPU_REGS_SVH

// word index of each register, taken from address bits 3:1
`define REG_DDR2_PHY_READY 3'd0
`define REG_DDR2_SOFT_ADDR 3'd1
`define REG_DDR2_RESET     3'd2
`define REG_DDR2_BUS_RQST  3'd3
`define REG_DDR2_BUS_GRNTD 3'd4

`endif

//--- hw/ddr2_cpu_pkg.sv
package ddr2_cpu_pkg;

  localparam int WB_DATA_W  = 16;
  localparam int WB_ADDR_W  = 32;
  localparam int WB_SEL_W   = WB_DATA_W / 8;
  localparam int DDR_ADDR_W = 32;

  typedef logic [WB_DATA_W-1:0]  wb_data_t;
  typedef logic [WB_ADDR_W-1:0]  wb_addr_t;
  typedef logic [WB_SEL_W-1:0]   wb_sel_t;   // one bit per byte lane
  typedef logic [DDR_ADDR_W-1:0] ddr_addr_t; // word address, page joined with word index

  // owner code, also read back in the PHY_READY register bits 9:8
  typedef enum logic [1:0] {
    owner_idle   = 2'd0,
    owner_fabric = 2'd1,
    owner_cpu    = 2'd2
  } arb_owner_e;

  typedef enum logic [1:0] {
    init_reset = 2'd0,
    init_calib = 2'd1,
    init_ready = 2'd2
  } init_state_e;

endpackage

//--- hw/ddr2_cpu_regs.sv
`include "ddr2_cpu_regs.svh"

module ddr2_cpu_regs #(
  parameter int SOFT_ADDR_BITS = 8
) (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  input  logic                       reg_stb_i,
  input  logic                       wb_we_i,
  input  ddr2_cpu_pkg::wb_sel_t      wb_sel_i,
  input  ddr2_cpu_pkg::wb_addr_t     wb_adr_i,
  input  ddr2_cpu_pkg::wb_data_t     wb_dat_i,
  output ddr2_cpu_pkg::wb_data_t     reg_dat_o,
  output logic                       reg_ack_o,
  output logic [SOFT_ADDR_BITS-1:0]  soft_addr_o,
  input  logic                       phy_ready_i,
  input  ddr2_cpu_pkg::arb_owner_e   arb_owner_i,
  output logic                       ddr2_reset_o,
  output logic                       bus_rqst_o,
  input  logic                       bus_grntd_i
);

  ddr2_cpu_pkg::wb_data_t soft_addr_q;
  logic [2:0]             rd_idx_q;    // word index of the last access
  logic                   ack_q;
  logic                   reset_q;
  logic                   rqst_q;
  logic                   accept;

  assign accept      = reg_stb_i & ~ack_q;
  assign soft_addr_o = soft_addr_q[SOFT_ADDR_BITS-1:0];
  assign reg_ack_o   = ack_q;
  assign ddr2_reset_o = reset_q;
  assign bus_rqst_o  = rqst_q;

  always_ff @(posedge wb_clk_i) begin
    ack_q   <= 1'b0;
    reset_q <= 1'b0; // pulse lasts only the ack cycle
    if (wb_rst_i) begin
      soft_addr_q <= '0;
      rqst_q      <= 1'b0;
    end else if (accept) begin
      ack_q <= 1'b1;
      if (wb_we_i) begin
        case (wb_adr_i[3:1])
          `REG_DDR2_SOFT_ADDR: begin
            if (wb_sel_i[0]) begin
              soft_addr_q[7:0] <= wb_dat_i[7:0];
            end
            if (wb_sel_i[1]) begin
              soft_addr_q[15:8] <= wb_dat_i[15:8];
            end
          end
          `REG_DDR2_RESET: begin
            if (wb_sel_i[0]) begin
              reset_q <= wb_dat_i[0];
            end
          end
          `REG_DDR2_BUS_RQST: begin
            if (wb_sel_i[0]) begin
              rqst_q <= wb_dat_i[0];
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      rd_idx_q <= wb_adr_i[3:1];
    end
  end

  // readback from the index captured with the strobe
  always_comb begin
    case (rd_idx_q)
      `REG_DDR2_PHY_READY: reg_dat_o = {6'b0, arb_owner_i, 7'b0, phy_ready_i};
      `REG_DDR2_SOFT_ADDR: reg_dat_o = soft_addr_q;
      `REG_DDR2_RESET:     reg_dat_o = '0;
      `REG_DDR2_BUS_RQST:  reg_dat_o = {15'b0, rqst_q};
      `REG_DDR2_BUS_GRNTD: reg_dat_o = {15'b0, bus_grntd_i};
      default:             reg_dat_o = '0;
    endcase
  end

endmodule

//--- hw/ddr2_phy_init.sv
module ddr2_phy_init #(
  parameter int INIT_CYCLES = 16
) (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic ddr2_reset_i,
  output logic phy_ready_o
);

  localparam int CNT_W = (INIT_CYCLES > 2) ? $clog2(INIT_CYCLES) : 1;

  ddr2_cpu_pkg::init_state_e state_q;
  logic [CNT_W-1:0]          cnt_q;   // cycles since the last reset event

  // stands in for PHY calibration, restarted by either reset
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || ddr2_reset_i) begin
      state_q <= ddr2_cpu_pkg::init_reset;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ddr2_cpu_pkg::init_reset: begin
          state_q <= ddr2_cpu_pkg::init_calib;
          cnt_q   <= cnt_q + 1'b1;
        end
        ddr2_cpu_pkg::init_calib: begin
          if (cnt_q == CNT_W'(INIT_CYCLES - 1)) begin
            state_q <= ddr2_cpu_pkg::init_ready; // ready from event + INIT_CYCLES
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  assign phy_ready_o = (state_q == ddr2_cpu_pkg::init_ready);

endmodule

//--- hw/ddr2_bus_arbiter.sv
module ddr2_bus_arbiter (
  input  logic                     wb_clk_i,
  input  logic                     wb_rst_i,
  input  logic                     phy_ready_i,
  input  logic                     fab_req_i,
  input  logic                     cpu_req_i,
  output logic                     fab_gnt_o,
  output logic                     cpu_gnt_o,
  output ddr2_cpu_pkg::arb_owner_e owner_o,
  input  logic                     fab_cmd_valid_i,
  input  logic                     fab_cmd_rnw_i,
  input  ddr2_cpu_pkg::ddr_addr_t  fab_cmd_addr_i,
  input  ddr2_cpu_pkg::wb_data_t   fab_wr_data_i,
  input  logic                     cpu_cmd_valid_i,
  input  logic                     cpu_cmd_rnw_i,
  input  ddr2_cpu_pkg::ddr_addr_t  cpu_cmd_addr_i,
  input  ddr2_cpu_pkg::wb_data_t   cpu_wr_data_i,
  output logic                     ddr2_cmd_valid_o,
  output logic                     ddr2_cmd_rnw_o,
  output ddr2_cpu_pkg::ddr_addr_t  ddr2_cmd_addr_o,
  output ddr2_cpu_pkg::wb_data_t   ddr2_wr_data_o
);

  ddr2_cpu_pkg::arb_owner_e owner_q;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !phy_ready_i) begin
      owner_q <= ddr2_cpu_pkg::owner_idle;
    end else begin
      case (owner_q)
        ddr2_cpu_pkg::owner_idle: begin
          if (fab_req_i) begin
            owner_q <= ddr2_cpu_pkg::owner_fabric; // fabric has priority
          end else if (cpu_req_i) begin
            owner_q <= ddr2_cpu_pkg::owner_cpu;
          end
        end
        ddr2_cpu_pkg::owner_fabric: begin
          if (!fab_req_i) owner_q <= ddr2_cpu_pkg::owner_idle;
        end
        ddr2_cpu_pkg::owner_cpu: begin
          if (!cpu_req_i) owner_q <= ddr2_cpu_pkg::owner_idle;
        end
        default: owner_q <= ddr2_cpu_pkg::owner_idle;
      endcase
    end
  end

  // a falling phy_ready cuts the grant before the state catches up
  assign fab_gnt_o = phy_ready_i && (owner_q == ddr2_cpu_pkg::owner_fabric);
  assign cpu_gnt_o = phy_ready_i && (owner_q == ddr2_cpu_pkg::owner_cpu);
  assign owner_o   = owner_q;

  always_comb begin
    ddr2_cmd_valid_o = 1'b0;
    ddr2_cmd_rnw_o   = 1'b0;
    ddr2_cmd_addr_o  = '0;
    ddr2_wr_data_o   = '0;
    if (fab_gnt_o) begin
      ddr2_cmd_valid_o = fab_cmd_valid_i;
      ddr2_cmd_rnw_o   = fab_cmd_rnw_i;
      ddr2_cmd_addr_o  = fab_cmd_addr_i;
      ddr2_wr_data_o   = fab_wr_data_i;
    end else if (cpu_gnt_o) begin
      ddr2_cmd_valid_o = cpu_cmd_valid_i;
      ddr2_cmd_rnw_o   = cpu_cmd_rnw_i;
      ddr2_cmd_addr_o  = cpu_cmd_addr_i;
      ddr2_wr_data_o   = cpu_wr_data_i;
    end
  end

endmodule

//--- hw/ddr2_cpu_window.sv
module ddr2_cpu_window #(
  parameter int SOFT_ADDR_BITS = 8,
  parameter int WIN_WORD_BITS  = 4
) (
  input  logic                       wb_clk_i,
  input  logic                       wb_rst_i,
  input  logic                       win_stb_i,
  input  logic                       wb_we_i,
  input  ddr2_cpu_pkg::wb_addr_t     wb_adr_i,
  input  ddr2_cpu_pkg::wb_data_t     wb_dat_i,
  output ddr2_cpu_pkg::wb_data_t     win_dat_o,
  output logic                       win_ack_o,
  input  logic [SOFT_ADDR_BITS-1:0]  soft_addr_i,
  input  logic                       granted_i,
  output logic                       cmd_valid_o,
  output logic                       cmd_rnw_o,
  output ddr2_cpu_pkg::ddr_addr_t    cmd_addr_o,
  output ddr2_cpu_pkg::wb_data_t     wr_data_o,
  input  logic                       cmd_ready_i,
  input  logic                       rd_valid_i,
  input  ddr2_cpu_pkg::wb_data_t     rd_data_i
);

  localparam int PAGE_WORD_W = SOFT_ADDR_BITS + WIN_WORD_BITS;

  typedef enum logic [1:0] {
    win_idle = 2'd0,
    win_cmd  = 2'd1,
    win_wait = 2'd2,
    win_ack  = 2'd3
  } win_state_e;

  win_state_e               state_q;
  logic [PAGE_WORD_W-1:0]   page_word;
  logic                     rnw_q;
  ddr2_cpu_pkg::ddr_addr_t  addr_q;
  ddr2_cpu_pkg::wb_data_t   wr_data_q;
  ddr2_cpu_pkg::wb_data_t   rd_data_q;

  assign page_word = {soft_addr_i, wb_adr_i[WIN_WORD_BITS:1]};

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q <= win_idle;
    end else begin
      case (state_q)
        win_idle: begin
          if (win_stb_i) begin
            state_q <= granted_i ? win_cmd : win_ack; // no grant, ack at once
          end
        end
        win_cmd: begin
          if (!granted_i) begin
            state_q <= win_ack; // grant lost while waiting
          end else if (cmd_ready_i) begin
            state_q <= rnw_q ? win_wait : win_ack;
          end
        end
        win_wait: begin
          if (rd_valid_i) state_q <= win_ack;
        end
        default: state_q <= win_idle;
      endcase
    end
  end

  // command fields and read data
  always_ff @(posedge wb_clk_i) begin
    if (state_q == win_idle && win_stb_i) begin
      rnw_q     <= ~wb_we_i;
      addr_q    <= ddr2_cpu_pkg::ddr_addr_t'(page_word);
      wr_data_q <= wb_dat_i;
      rd_data_q <= '0;
    end else if (state_q == win_wait && rd_valid_i) begin
      rd_data_q <= rd_data_i;
    end
  end

  assign cmd_valid_o = (state_q == win_cmd);
  assign cmd_rnw_o   = rnw_q;
  assign cmd_addr_o  = addr_q;
  assign wr_data_o   = wr_data_q;
  assign win_ack_o   = (state_q == win_ack);
  assign win_dat_o   = rd_data_q;

endmodule

//--- hw/ddr2_cpu_interface.sv
module ddr2_cpu_interface #(
  parameter int SOFT_ADDR_BITS = 8,
  parameter int WIN_WORD_BITS  = 4,
  parameter int INIT_CYCLES    = 16
) (
  input  logic                    wb_clk_i,
  input  logic                    wb_rst_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  ddr2_cpu_pkg::wb_sel_t   wb_sel_i,
  input  ddr2_cpu_pkg::wb_addr_t  wb_adr_i,
  input  ddr2_cpu_pkg::wb_data_t  wb_dat_i,
  output ddr2_cpu_pkg::wb_data_t  wb_dat_o,
  output logic                    wb_ack_o,
  input  logic                    fab_req_i,
  output logic                    fab_gnt_o,
  input  logic                    fab_cmd_valid_i,
  input  logic                    fab_cmd_rnw_i,
  input  ddr2_cpu_pkg::ddr_addr_t fab_cmd_addr_i,
  input  ddr2_cpu_pkg::wb_data_t  fab_wr_data_i,
  output logic                    ddr2_cmd_valid_o,
  output logic                    ddr2_cmd_rnw_o,
  output ddr2_cpu_pkg::ddr_addr_t ddr2_cmd_addr_o,
  output ddr2_cpu_pkg::wb_data_t  ddr2_wr_data_o,
  input  logic                    ddr2_cmd_ready_i,
  input  logic                    ddr2_rd_valid_i,
  input  ddr2_cpu_pkg::wb_data_t  ddr2_rd_data_i
);

  logic                      win_sel;
  logic                      reg_stb;
  logic                      win_stb;
  ddr2_cpu_pkg::wb_data_t    reg_dat;
  ddr2_cpu_pkg::wb_data_t    win_dat;
  logic                      reg_ack;
  logic                      win_ack;
  logic [SOFT_ADDR_BITS-1:0] soft_addr;
  logic                      phy_ready;
  logic                      ddr2_reset;
  logic                      bus_rqst;
  logic                      bus_grntd;
  ddr2_cpu_pkg::arb_owner_e  owner;
  logic                      cpu_cmd_valid;
  logic                      cpu_cmd_rnw;
  ddr2_cpu_pkg::ddr_addr_t   cpu_cmd_addr;
  ddr2_cpu_pkg::wb_data_t    cpu_wr_data;

  assign win_sel = wb_adr_i[31]; // upper half is the memory window
  assign reg_stb = wb_cyc_i & wb_stb_i & ~win_sel;
  assign win_stb = wb_cyc_i & wb_stb_i & win_sel;

  assign wb_ack_o = win_sel ? win_ack : reg_ack;
  assign wb_dat_o = win_sel ? win_dat : reg_dat;

  ddr2_cpu_regs #(.SOFT_ADDR_BITS(SOFT_ADDR_BITS)) u_regs (
    .wb_clk_i, .wb_rst_i, .reg_stb_i(reg_stb), .wb_we_i, .wb_sel_i, .wb_adr_i, .wb_dat_i,
    .reg_dat_o(reg_dat), .reg_ack_o(reg_ack), .soft_addr_o(soft_addr),
    .phy_ready_i(phy_ready), .arb_owner_i(owner), .ddr2_reset_o(ddr2_reset),
    .bus_rqst_o(bus_rqst), .bus_grntd_i(bus_grntd)
  );

  ddr2_phy_init #(.INIT_CYCLES(INIT_CYCLES)) u_phy_init (
    .wb_clk_i, .wb_rst_i, .ddr2_reset_i(ddr2_reset), .phy_ready_o(phy_ready)
  );

  ddr2_bus_arbiter u_arbiter (
    .wb_clk_i, .wb_rst_i, .phy_ready_i(phy_ready),
    .fab_req_i, .cpu_req_i(bus_rqst), .fab_gnt_o, .cpu_gnt_o(bus_grntd), .owner_o(owner),
    .fab_cmd_valid_i, .fab_cmd_rnw_i, .fab_cmd_addr_i, .fab_wr_data_i,
    .cpu_cmd_valid_i(cpu_cmd_valid), .cpu_cmd_rnw_i(cpu_cmd_rnw),
    .cpu_cmd_addr_i(cpu_cmd_addr), .cpu_wr_data_i(cpu_wr_data),
    .ddr2_cmd_valid_o, .ddr2_cmd_rnw_o, .ddr2_cmd_addr_o, .ddr2_wr_data_o
  );

  ddr2_cpu_window #(
    .SOFT_ADDR_BITS(SOFT_ADDR_BITS),
    .WIN_WORD_BITS (WIN_WORD_BITS)
  ) u_window (
    .wb_clk_i, .wb_rst_i, .win_stb_i(win_stb), .wb_we_i, .wb_adr_i, .wb_dat_i,
    .win_dat_o(win_dat), .win_ack_o(win_ack), .soft_addr_i(soft_addr),
    .granted_i(bus_grntd), .cmd_valid_o(cpu_cmd_valid), .cmd_rnw_o(cpu_cmd_rnw),
    .cmd_addr_o(cpu_cmd_addr), .wr_data_o(cpu_wr_data),
    .cmd_ready_i(ddr2_cmd_ready_i), .rd_valid_i(ddr2_rd_valid_i), .rd_data_i(ddr2_rd_data_i)
  );

endmodule

//--- verification/ddr2_cpu_interface_properties.sv
module ddr2_cpu_interface_properties (
  input logic                    wb_clk_i,
  input logic                    wb_rst_i,
  input logic                    wb_ack_o,
  input logic                    ddr2_cmd_valid_o,
  input logic                    ddr2_cmd_rnw_o,
  input ddr2_cpu_pkg::ddr_addr_t ddr2_cmd_addr_o,
  input ddr2_cpu_pkg::wb_data_t  ddr2_wr_data_o,
  input logic                    ddr2_cmd_ready_i,
  input logic                    fab_gnt_o,
  input logic                    bus_grntd,
  input logic                    phy_ready
);

  int violations = 0;

  ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
    else begin $error("wb_ack_o high for two cycles"); violations++; end

  // command is held with stable fields until accepted
  cmd_held: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ddr2_cmd_valid_o && !ddr2_cmd_ready_i |=> ddr2_cmd_valid_o && $stable(ddr2_cmd_rnw_o)
      && $stable(ddr2_cmd_addr_o) && $stable(ddr2_wr_data_o))
    else begin $error("DDR2 command changed before ready"); violations++; end

  grant_onehot: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(fab_gnt_o && bus_grntd))
    else begin $error("fabric and CPU granted together"); violations++; end

  no_grant_unready: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !phy_ready |-> !fab_gnt_o && !bus_grntd)
    else begin $error("grant given while phy_ready is low"); violations++; end

endmodule

bind ddr2_cpu_interface ddr2_cpu_interface_properties u_props (
  .wb_clk_i, .wb_rst_i, .wb_ack_o, .ddr2_cmd_valid_o, .ddr2_cmd_rnw_o, .ddr2_cmd_addr_o,
  .ddr2_wr_data_o, .ddr2_cmd_ready_i, .fab_gnt_o, .bus_grntd, .phy_ready
);

//--- verification/tb_ddr2_cpu_interface.sv
module tb_ddr2_cpu_interface;

  logic                    wb_clk_i;
  logic                    wb_rst_i;
  logic                    wb_cyc_i;
  logic                    wb_stb_i;
  logic                    wb_we_i;
  ddr2_cpu_pkg::wb_sel_t   wb_sel_i;
  ddr2_cpu_pkg::wb_addr_t  wb_adr_i;
  ddr2_cpu_pkg::wb_data_t  wb_dat_i;
  ddr2_cpu_pkg::wb_data_t  wb_dat_o;
  logic                    wb_ack_o;
  logic                    fab_req_i;
  logic                    fab_gnt_o;
  logic                    fab_cmd_valid_i;
  logic                    fab_cmd_rnw_i;
  ddr2_cpu_pkg::ddr_addr_t fab_cmd_addr_i;
  ddr2_cpu_pkg::wb_data_t  fab_wr_data_i;
  logic                    ddr2_cmd_valid_o;
  logic                    ddr2_cmd_rnw_o;
  ddr2_cpu_pkg::ddr_addr_t ddr2_cmd_addr_o;
  ddr2_cpu_pkg::wb_data_t  ddr2_wr_data_o;
  logic                    ddr2_cmd_ready_i;
  logic                    ddr2_rd_valid_i;
  ddr2_cpu_pkg::wb_data_t  ddr2_rd_data_i;

  logic [15:0]            case_op[$];  // two letter operation name
  ddr2_cpu_pkg::wb_addr_t case_adr[$];
  ddr2_cpu_pkg::wb_sel_t  case_sel[$];
  ddr2_cpu_pkg::wb_data_t case_dat[$];
  ddr2_cpu_pkg::wb_data_t case_exp[$];
  ddr2_cpu_pkg::wb_data_t mem [0:4095]; // page and word index give 12 address bits
  int                     errors = 0;
  int                     checks = 0;
  int                     cycles = 0;
  int                     cycle_limit = 0;

  ddr2_cpu_interface u_ddr2_cpu_interface (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  task automatic load_cases();
    int                     fd;
    string                  line;
    logic [15:0]            op;
    ddr2_cpu_pkg::wb_addr_t adr;
    ddr2_cpu_pkg::wb_sel_t  sel;
    ddr2_cpu_pkg::wb_data_t dat;
    ddr2_cpu_pkg::wb_data_t expv;
    fd = $fopen("verification/ddr2_cpu_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/ddr2_cpu_cases.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin // skip blank and comment lines
        if ($sscanf(line, "%s %h %h %h %h", op, adr, sel, dat, expv) == 5) begin
          case_op.push_back(op);
          case_adr.push_back(adr);
          case_sel.push_back(sel);
          case_dat.push_back(dat);
          case_exp.push_back(expv);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic check_data(input string what, input ddr2_cpu_pkg::wb_data_t got,
                            input ddr2_cpu_pkg::wb_data_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[FAIL] t=%0t %s: data %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_flag(input string what, input bit got, input bit want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[FAIL] t=%0t %s: flag %b, expected %b", $time, what, got, want);
    end
  endtask

  // one Wishbone cycle, held until ack
  task automatic bus_access(input ddr2_cpu_pkg::wb_addr_t adr, input logic we,
                            input ddr2_cpu_pkg::wb_sel_t sel, input ddr2_cpu_pkg::wb_data_t dat,
                            output ddr2_cpu_pkg::wb_data_t rdat);
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_sel_i = sel;
    wb_adr_i = adr;
    wb_dat_i = dat;
    @(negedge wb_clk_i);
    while (!wb_ack_o) @(negedge wb_clk_i);
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic run_case(input int i);
    ddr2_cpu_pkg::wb_data_t rdat;
    int                     err_before;
    string                  tag;
    err_before = errors;
    tag = $sformatf("case %0d", i);
    case (case_op[i])
      "rw", "ww": bus_access(case_adr[i], 1'b1, case_sel[i], case_dat[i], rdat);
      "rr", "wr": begin
        bus_access(case_adr[i], 1'b0, case_sel[i], '0, rdat);
        check_data(tag, rdat, case_exp[i]);
      end
      "fr": begin
        @(negedge wb_clk_i);
        fab_req_i = case_dat[i][0];
        for (int n = 0; n < 8 && fab_gnt_o !== case_exp[i][0]; n++) @(negedge wb_clk_i);
        check_flag(tag, fab_gnt_o, case_exp[i][0]);
      end
      "wt": begin
        rdat = '0;
        while (rdat[0] !== 1'b1) bus_access(case_adr[i], 1'b0, case_sel[i], '0, rdat);
        check_data(tag, rdat, case_exp[i]); // owner bits come with the ready bit
      end
      default: begin
        errors++;
        $display("%s: unknown operation %s in the case file", tag, case_op[i]);
      end
    endcase
    $display("%s %s %h: %s", tag, case_op[i], case_adr[i], (errors == err_before) ? "ok" : "bad");
  endtask

  // DDR2 memory model: random accept delay, read data two cycles after accept
  initial begin
    logic                    acc_rnw;
    ddr2_cpu_pkg::ddr_addr_t acc_addr;
    ddr2_cpu_pkg::wb_data_t  acc_data;
    ddr2_cpu_pkg::wb_data_t  rd_word;
    int unsigned             wait_left;
    int                      rd_left;
    bit                      cmd_seen;
    void'($urandom(32'h85bf_126e));
    for (int a = 0; a < 4096; a++) mem[a] = 16'ha000 ^ 16'(a);
    ddr2_cmd_ready_i = 1'b0;
    ddr2_rd_valid_i  = 1'b0;
    ddr2_rd_data_i   = '0;
    rd_left  = 0;
    cmd_seen = 1'b0;
    forever begin
      @(negedge wb_clk_i);
      ddr2_rd_valid_i = 1'b0;
      if (rd_left > 0) begin
        rd_left--;
        if (rd_left == 0) begin
          ddr2_rd_valid_i = 1'b1;
          ddr2_rd_data_i  = rd_word;
        end
      end
      if (ddr2_cmd_ready_i) begin // accepted on the last rising edge
        ddr2_cmd_ready_i = 1'b0;
        cmd_seen = 1'b0;
        if (acc_rnw) begin
          rd_word = mem[acc_addr[11:0]];
          rd_left = 1;
        end else begin
          mem[acc_addr[11:0]] = acc_data;
        end
      end else if (ddr2_cmd_valid_o) begin
        if (!cmd_seen) begin
          cmd_seen  = 1'b1;
          wait_left = $urandom % 4;
        end
        if (wait_left == 0) begin
          ddr2_cmd_ready_i = 1'b1;
          acc_rnw  = ddr2_cmd_rnw_o;
          acc_addr = ddr2_cmd_addr_o;
          acc_data = ddr2_wr_data_o;
        end else begin
          wait_left--;
        end
      end
    end
  end

  initial begin
    wait (cycle_limit != 0);
    while (cycles < cycle_limit) begin
      @(posedge wb_clk_i);
      cycles++;
    end
    $display("timeout: the run went past its limit of %0d cycles", cycle_limit);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    wb_rst_i        = 1'b1;
    wb_cyc_i        = 1'b0;
    wb_stb_i        = 1'b0;
    wb_we_i         = 1'b0;
    wb_sel_i        = '0;
    wb_adr_i        = '0;
    wb_dat_i        = '0;
    fab_req_i       = 1'b0;
    fab_cmd_valid_i = 1'b0;
    fab_cmd_rnw_i   = 1'b0;
    fab_cmd_addr_i  = '0;
    fab_wr_data_i   = '0;
    load_cases();
    cycle_limit = case_op.size() * 64;
    repeat (4) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    if (case_op.size() == 0) $display("no cases were loaded, nothing was tested");
    for (int i = 0; i < case_op.size(); i++) run_case(i);
    $display("tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             case_op.size(), checks, errors, u_ddr2_cpu_interface.u_props.violations);
    if (case_op.size() > 0 && errors == 0 && u_ddr2_cpu_interface.u_props.violations == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- verification/ddr2_cpu_cases.txt
# op adr sel dat exp, hex; rw/rr register write/read, ww/wr window write/read, exp is read data
# fr sets fab_req_i from dat bit 0 and expects fab_gnt_o = exp bit 0, wt polls adr until bit 0
wt 00000000 3 0000 0001
rw 00000002 3 1234 0000
rw 00000002 1 00ab 0000
rr 00000002 3 0000 12ab
rw 00000002 2 cd00 0000
rr 00000002 3 0000 cdab
rw 00000004 1 0001 0000
rr 00000000 3 0000 0000
wt 00000000 3 0000 0001
rw 00000006 1 0001 0000
rr 00000008 3 0000 0001
rr 00000000 3 0000 0201
rw 00000002 3 0001 0000
ww 80000000 3 1111 0000
ww 80000006 3 3333 0000
rw 00000002 3 0002 0000
ww 80000000 3 2222 0000
ww 80000006 3 4444 0000
wr 80000000 3 0000 2222
wr 80000006 3 0000 4444
rw 00000002 3 0001 0000
wr 80000000 3 0000 1111
wr 80000006 3 0000 3333
wr 8000000a 3 0000 a015
rw 00000006 1 0000 0000
ww 80000000 3 9999 0000
wr 80000000 3 0000 0000
rw 00000006 1 0001 0000
wr 80000000 3 0000 1111
rw 00000006 1 0000 0000
fr 00000000 0 0001 0001
rw 00000006 1 0001 0000
rr 00000008 3 0000 0000
rr 00000000 3 0000 0101
fr 00000000 0 0000 0000
rr 00000008 3 0000 0001

//--- ddr2_cpu_interface.f
+incdir+include
hw/ddr2_cpu_pkg.sv
hw/ddr2_cpu_regs.sv
hw/ddr2_phy_init.sv
hw/ddr2_bus_arbiter.sv
hw/ddr2_cpu_window.sv
hw/ddr2_cpu_interface.sv
verification/ddr2_cpu_interface_properties.sv
verification/tb_ddr2_cpu_interface.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ddr2_cpu_interface
FILELIST  ?= ddr2_cpu_interface.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= All tests passed
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
